// File: source/spi_cmd_pkg.sv
package spi_cmd_pkg;

    // Frame geometry, fixed by the link protocol
    localparam int unsigned FRAME_W  = 22;  // One serial frame
    localparam int unsigned OP_W     = 2;   // Opcode field
    localparam int unsigned ADDR_W   = 4;   // Register address field
    localparam int unsigned DATA_W   = 16;  // Operand and register width
    localparam int unsigned NUM_REGS = 16;  // Register bank depth

    // Plain vectors for widths with a meaning
    typedef logic [FRAME_W-1:0] frame_t;    // Raw frame as seen on the wire
    typedef logic [ADDR_W-1:0]  reg_addr_t; // Register index
    typedef logic [DATA_W-1:0]  reg_data_t; // Register contents, operand

    // Command operations, codes fixed by the host side
    typedef enum logic [OP_W-1:0] {
        NOP   = 2'd0,   // No effect, still answers
        WRITE = 2'd1,   // Store operand
        READ  = 2'd2,   // Return register
        ADD   = 2'd3    // Accumulate, wraps at 16 bits
    } opcode_t;

    // Decoded command
    // Same bit order as a frame: op 21:20, addr 19:16, operand 15:0
    typedef struct packed {
        opcode_t   op;
        reg_addr_t addr;
        reg_data_t operand;
    } cmd_t;

    // Executed result, also the response frame layout
    // value: operand for WRITE, contents for READ, sum for ADD, zero for NOP
    typedef struct packed {
        opcode_t   op;
        reg_addr_t addr;
        reg_data_t value;
    } result_t;

endpackage

// File: source/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
    input  logic                sclk,
    input  logic                rst_n,
    input  logic                mosi,      // Host data, sampled on rising sclk
    input  logic                ss_n,      // Frame window, active low
    input  spi_cmd_pkg::frame_t tx_frame,  // Response for the next frame
    input  logic                tx_load,   // Load strobe, honoured in IDLE only
    output logic                miso,      // Response bit, low outside a frame
    output spi_cmd_pkg::frame_t rx_frame,  // Last complete frame
    output logic                rx_valid   // One-cycle pulse per full frame
);
    import spi_cmd_pkg::*;

    typedef enum logic {
        IDLE,
        TRANSMIT
    } slave_state_t;

    slave_state_t state, state_nxt;
    logic [4:0]   bit_cnt;      // 0 to 21 within a frame
    logic         last_bit;     // 22nd sample on this edge
    frame_t       rx_shifter;
    frame_t       tx_shifter;
    frame_t       tx_hold;      // Response kept until the next load

    // Final sample only counts while still selected
    assign last_bit = (state == TRANSMIT) && !ss_n && (bit_cnt == 5'(FRAME_W - 1));

    // Next state and miso
    always_comb begin
        state_nxt = state;
        miso      = 1'b0;  // Quiet while idle
        case (state)
            IDLE: begin
                if (!ss_n) begin
                    state_nxt = TRANSMIT;
                end
            end
            TRANSMIT: begin
                miso = tx_shifter[FRAME_W-1];  // MSB first
                // Done after 22 bits, or aborted by an early ss_n rise
                if (last_bit || ss_n) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Control and transmit side
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            bit_cnt    <= '0;
            rx_valid   <= 1'b0;
            tx_shifter <= '0;
            tx_hold    <= '0;
        end else begin
            state    <= state_nxt;
            rx_valid <= last_bit;  // Aborted frames never strobe
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    // A response arriving mid-frame is dropped, it only lands here
                    if (tx_load) begin
                        tx_hold    <= tx_frame;
                        tx_shifter <= tx_frame;
                    end else begin
                        tx_shifter <= tx_hold;  // Restores the word after an abort
                    end
                end
                TRANSMIT: begin
                    if (!ss_n) begin
                        bit_cnt    <= bit_cnt + 5'd1;
                        tx_shifter <= {tx_shifter[FRAME_W-2:0], 1'b0};
                    end
                end
                default: bit_cnt <= '0;
            endcase
        end
    end

    // Receive payload
    always_ff @(posedge sclk) begin
        if (state == TRANSMIT && !ss_n) begin
            rx_shifter <= {rx_shifter[FRAME_W-2:0], mosi};
        end
        if (last_bit) begin
            rx_frame <= {rx_shifter[FRAME_W-2:0], mosi};  // Include the bit on the wire now
        end
    end

endmodule

// File: source/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
    input  logic                sclk,
    input  logic                rst_n,
    input  spi_cmd_pkg::frame_t rx_frame,   // Raw frame from the shifter
    input  logic                rx_valid,
    output spi_cmd_pkg::cmd_t   cmd,        // Fields split out
    output logic                cmd_valid   // rx_valid delayed by one cycle
);
    import spi_cmd_pkg::*;

    // Frame field positions
    localparam int unsigned OP_LSB   = 20;
    localparam int unsigned ADDR_LSB = 16;
    localparam int unsigned DATA_LSB = 0;

    opcode_t   op_fld;
    reg_addr_t addr_fld;
    reg_data_t data_fld;

    // Slice the frame
    always_comb begin
        op_fld   = opcode_t'(rx_frame[OP_LSB +: OP_W]);
        addr_fld = rx_frame[ADDR_LSB +: ADDR_W];
        data_fld = rx_frame[DATA_LSB +: DATA_W];
    end

    // Strobe
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= rx_valid;
        end
    end

    // Command register, updated only on a new frame
    always_ff @(posedge sclk) begin
        if (rx_valid) begin
            cmd.op      <= op_fld;
            cmd.addr    <= addr_fld;
            cmd.operand <= data_fld;
        end
    end

endmodule

// File: source/reg_execute.sv
`timescale 1ns/1ps

module reg_execute (
    input  logic                 sclk,
    input  logic                 rst_n,
    input  spi_cmd_pkg::cmd_t    cmd,
    input  logic                 cmd_valid,
    output spi_cmd_pkg::result_t res,        // Outcome of the last command
    output logic                 res_valid   // cmd_valid delayed by one cycle
);
    import spi_cmd_pkg::*;

    reg_data_t regs [NUM_REGS];  // Register bank
    reg_data_t cur;              // Addressed register, before update
    reg_data_t sum;              // Wraps modulo 2^16
    reg_data_t value;            // Result value per opcode

    assign cur = regs[cmd.addr];
    assign sum = cur + cmd.operand;  // Carry out discarded

    // Result value selection
    always_comb begin
        case (cmd.op)
            WRITE:   value = cmd.operand;
            READ:    value = cur;
            ADD:     value = sum;
            default: value = '0;  // NOP
        endcase
    end

    // Bank update and strobe
    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            res_valid <= 1'b0;
        end else begin
            res_valid <= cmd_valid;
            if (cmd_valid) begin
                case (cmd.op)
                    WRITE:   regs[cmd.addr] <= cmd.operand;
                    ADD:     regs[cmd.addr] <= sum;
                    default: ;  // READ and NOP leave the bank alone
                endcase
            end
        end
    end

    // Result register, same edge as the bank write
    always_ff @(posedge sclk) begin
        if (cmd_valid) begin
            res.op    <= cmd.op;
            res.addr  <= cmd.addr;   // Echoed back to the host
            res.value <= value;
        end
    end

endmodule

// File: source/resp_result.sv
`timescale 1ns/1ps

module resp_result (
    input  logic                 sclk,
    input  logic                 rst_n,
    input  spi_cmd_pkg::result_t res,
    input  logic                 res_valid,
    output spi_cmd_pkg::frame_t  tx_frame,  // Held between strobes
    output logic                 tx_load    // One-cycle load pulse to the slave
);
    import spi_cmd_pkg::*;

    frame_t resp_word;

    // Response frame shares the result layout bit for bit
    assign resp_word = frame_t'(res);

    always_ff @(posedge sclk or negedge rst_n) begin
        if (!rst_n) begin
            tx_frame <= '0;
            tx_load  <= 1'b0;
        end else begin
            tx_load <= res_valid;  // Every command answers, NOP included
            if (res_valid) begin
                tx_frame <= resp_word;
            end
        end
    end

endmodule

// File: source/spi_reg_top.sv
`timescale 1ns/1ps

module spi_reg_top (
    input  logic sclk,
    input  logic rst_n,
    input  logic mosi,
    input  logic ss_n,
    output logic miso
);
    import spi_cmd_pkg::*;

    // Stage to stage wiring
    frame_t  rx_frame;   // Slave to decode
    logic    rx_valid;
    cmd_t    cmd;        // Decode to execute
    logic    cmd_valid;
    result_t res;        // Execute to result
    logic    res_valid;
    frame_t  tx_frame;   // Result back to the slave
    logic    tx_load;

    // Serial shifter and frame FSM
    spi_slave spi_slave_i (
        .sclk     (sclk),
        .rst_n    (rst_n),
        .mosi     (mosi),
        .ss_n     (ss_n),
        .tx_frame (tx_frame),
        .tx_load  (tx_load),
        .miso     (miso),
        .rx_frame (rx_frame),
        .rx_valid (rx_valid)
    );

    cmd_decode cmd_decode_i (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .rx_frame  (rx_frame),
        .rx_valid  (rx_valid),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    // Register bank
    reg_execute reg_execute_i (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .res       (res),
        .res_valid (res_valid)
    );

    resp_result resp_result_i (
        .sclk      (sclk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .tx_frame  (tx_frame),
        .tx_load   (tx_load)
    );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic sclk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;  // 100 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        sclk = 1'b0;
        forever #(HALF_PERIOD) sclk = ~sclk;
    end

    // Reset held low, released on a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge sclk);
        rst_n <= 1'b1;
    end

endmodule

// File: tb/spi_reg_chk.sv
`timescale 1ns/1ps

module spi_reg_chk (
    input logic sclk,
    input logic rst_n,
    input logic ss_n,
    input logic miso,
    input logic rx_valid,   // Slave strobe
    input logic cmd_valid,  // Decode strobe
    input logic res_valid,  // Execute strobe
    input logic tx_load     // Response load strobe
);

    // Line stays quiet once deselected for two edges
    miso_quiet: assert property (@(posedge sclk) disable iff (!rst_n)
        (ss_n && $past(ss_n)) |-> !miso)
        else $error("miso driven high while ss_n has been high for two cycles");

    // Every stage strobes for a single cycle
    rx_valid_pulse: assert property (@(posedge sclk) disable iff (!rst_n)
        !(rx_valid && $past(rx_valid)))
        else $error("rx_valid high on two consecutive cycles");

    cmd_valid_pulse: assert property (@(posedge sclk) disable iff (!rst_n)
        !(cmd_valid && $past(cmd_valid)))
        else $error("cmd_valid high on two consecutive cycles");

    res_valid_pulse: assert property (@(posedge sclk) disable iff (!rst_n)
        !(res_valid && $past(res_valid)))
        else $error("res_valid high on two consecutive cycles");

    tx_load_pulse: assert property (@(posedge sclk) disable iff (!rst_n)
        !(tx_load && $past(tx_load)))
        else $error("tx_load high on two consecutive cycles");

    // Decode stage adds exactly one cycle
    cmd_follows_rx: assert property (@(posedge sclk) disable iff (!rst_n)
        cmd_valid == $past(rx_valid))
        else $error("cmd_valid does not follow rx_valid by one cycle");

endmodule

bind spi_reg_top spi_reg_chk spi_reg_chk_i (
    .sclk      (sclk),
    .rst_n     (rst_n),
    .ss_n      (ss_n),
    .miso      (miso),
    .rx_valid  (rx_valid),
    .cmd_valid (cmd_valid),
    .res_valid (res_valid),
    .tx_load   (tx_load)
);

// File: tb/spi_reg_tb.sv
`timescale 1ns/1ps

module spi_reg_tb;
    import spi_cmd_pkg::*;

    localparam int TOP_BIT = int'(FRAME_W) - 1;
    localparam int FULL_FRAME = int'(FRAME_W);
    localparam int ABORT_BITS = 10;                        // Bits sent before an early ss_n rise
    localparam int NUM_FRAMES = 89;                        // Frames sent over all tests
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 40 + 200; // Reset and margin included

    logic sclk;
    logic rst_n;
    logic mosi;
    logic ss_n;
    logic miso;

    reg_data_t model_regs [NUM_REGS];  // Reference register bank
    frame_t    exp_resp;               // Expected on miso during the next full frame
    int        errors;
    int        seed;

    tb_clkgen clkgen_i (
        .sclk  (sclk),
        .rst_n (rst_n)
    );

    spi_reg_top spi_reg_top_i (
        .sclk  (sclk),
        .rst_n (rst_n),
        .mosi  (mosi),
        .ss_n  (ss_n),
        .miso  (miso)
    );

    // One host frame sent MSB first; fewer than 22 bits aborts it
    task automatic spi_xfer(input frame_t tx, input int nbits, output frame_t rx);
        rx = '0;
        @(posedge sclk);
        ss_n <= 1'b0;             // Slave enters TRANSMIT on the next edge
        for (int n = 0; n < nbits; n++) begin
            @(posedge sclk);
            mosi <= tx[TOP_BIT - n];
            @(negedge sclk);
            rx[TOP_BIT - n] = miso;  // Bit shown in the cycle before its sampling edge
        end
        @(posedge sclk);          // Last sampling edge
        ss_n <= 1'b1;
        mosi <= 1'b0;
        repeat (8) @(posedge sclk);  // Gap covers the 4-cycle response path
    endtask

    // Response a command should produce under the protocol rules
    function automatic frame_t predict_resp(input opcode_t op, input reg_addr_t addr,
                                            input reg_data_t operand);
        reg_data_t value;
        case (op)
            WRITE:   value = operand;
            READ:    value = model_regs[addr];
            ADD:     value = model_regs[addr] + operand;  // Modulo 2^16
            default: value = '0;
        endcase
        return {op, addr, value};
    endfunction

    // Sends a full frame and checks the previous command's response
    task automatic send_cmd(input string name, input opcode_t op, input reg_addr_t addr,
                            input reg_data_t operand);
        frame_t got;
        frame_t next_resp;
        next_resp = predict_resp(op, addr, operand);
        spi_xfer({op, addr, operand}, FULL_FRAME, got);
        assert (got == exp_resp) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp_resp, got);
        end
        case (op)
            WRITE:   model_regs[addr] = operand;
            ADD:     model_regs[addr] = model_regs[addr] + operand;
            default: ;
        endcase
        exp_resp = next_resp;  // Shows up one frame later
    endtask

    // All registers read back zero after reset
    task automatic reset_readback();
        for (int a = 0; a < int'(NUM_REGS); a++) begin
            send_cmd("reset_readback", READ, reg_addr_t'(a), '0);
            send_cmd("reset_readback", NOP, reg_addr_t'(a), '0);
        end
    endtask

    // Random fill then read each register
    task automatic write_readback();
        int rnd;
        for (int a = 0; a < int'(NUM_REGS); a++) begin
            rnd = $random(seed);
            send_cmd("write_readback", WRITE, reg_addr_t'(a), reg_data_t'(rnd));
        end
        for (int a = 0; a < int'(NUM_REGS); a++) begin
            send_cmd("write_readback", READ, reg_addr_t'(a), '0);
        end
        send_cmd("write_readback", NOP, '0, '0);  // Flushes the last READ
    endtask

    // Accumulate with and without carry out of bit 15
    task automatic add_wraparound();
        int        rnd;
        reg_addr_t addr;
        reg_data_t operand;
        send_cmd("add_wraparound", WRITE, 4'd3, 16'hFFF0);
        send_cmd("add_wraparound", ADD, 4'd3, 16'h0025);  // Sum wraps to 0x0015
        send_cmd("add_wraparound", READ, 4'd3, '0);
        for (int n = 0; n < 6; n++) begin
            rnd     = $random(seed);
            addr    = reg_addr_t'(rnd >> 16);
            operand = reg_data_t'(rnd);
            send_cmd("add_wraparound", ADD, addr, operand);
            send_cmd("add_wraparound", READ, addr, '0);  // Register holds the sum
        end
        send_cmd("add_wraparound", NOP, '0, '0);
    endtask

    // Early ss_n rise drops the command and keeps the pending response
    task automatic abort_frame();
        frame_t partial;
        send_cmd("abort_frame", WRITE, 4'd7, 16'h1234);
        spi_xfer({WRITE, 4'd7, 16'hBEEF}, ABORT_BITS, partial);
        // Leading bits of the pending WRITE response
        assert (partial[TOP_BIT -: ABORT_BITS] == exp_resp[TOP_BIT -: ABORT_BITS]) else begin
            errors++;
            $display("[ERROR] abort_frame: expected %h, actual %h",
                     exp_resp[TOP_BIT -: ABORT_BITS], partial[TOP_BIT -: ABORT_BITS]);
        end
        send_cmd("abort_frame", READ, 4'd7, '0);  // Still carries the WRITE response
        send_cmd("abort_frame", NOP, '0, '0);     // READ shows the unchanged register
    endtask

    // Dependent commands to one address answer one frame late each
    task automatic pipeline_order();
        int rnd;
        rnd = $random(seed);
        send_cmd("pipeline_order", WRITE, 4'd9, reg_data_t'(rnd));
        rnd = $random(seed);
        send_cmd("pipeline_order", ADD, 4'd9, reg_data_t'(rnd));
        send_cmd("pipeline_order", READ, 4'd9, '0);
        send_cmd("pipeline_order", NOP, '0, '0);
    endtask

    initial begin
        ss_n     <= 1'b1;  // Deselected until the first frame
        mosi     <= 1'b0;
        errors   = 0;
        seed     = 28357;
        exp_resp = '0;     // First frame after reset shows an empty response
        for (int a = 0; a < int'(NUM_REGS); a++) begin
            model_regs[a] = '0;
        end
        @(posedge rst_n);
        repeat (2) @(posedge sclk);

        reset_readback();
        write_readback();
        add_wraparound();
        abort_frame();
        pipeline_order();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per frame against the 32 a frame takes
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sclk);
        $display("Timeout after %0d clock cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

endmodule

// File: sources.f
source/spi_cmd_pkg.sv
source/spi_slave.sv
source/cmd_decode.sv
source/reg_execute.sv
source/resp_result.sv
source/spi_reg_top.sv
tb/tb_clkgen.sv
tb/spi_reg_chk.sv
tb/spi_reg_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the SPI register slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module spi_reg_tb -f sources.f \
    --Mdir obj_dir -o spi_reg_sim > build.log 2>&1 \
    || { cat build.log; echo "Build FAILED"; exit 1; }

./obj_dir/spi_reg_sim > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
